//--- Bender.yml
package:
  name: icache_sub

sources:
  - verilog/icache_cfg_pkg.sv
  - verilog/icache_bus_pkg.sv
  - verilog/dual_port_ram.sv
  - verilog/addr_window.sv
  - verilog/icache_ctrl.sv
  - verilog/icache_top.sv
  - target: test
    files:
      - testbench/icache_assertions.sv
      - testbench/icache_tb.sv

//--- icache_sub.f
verilog/icache_cfg_pkg.sv
verilog/icache_bus_pkg.sv
verilog/dual_port_ram.sv
verilog/addr_window.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
testbench/icache_assertions.sv
testbench/icache_tb.sv

//--- testbench/icache_assertions.sv
`timescale 1ns/1ps

module icache_assertions (
    input logic        clk,
    input logic        rst_n,
    input logic        flush_i,
    input logic        fetch_ready_i,
    input logic        dec_valid_i,
    input logic        mem_addr_valid_i,
    input logic [31:0] mem_addr_i,
    input logic [3:0]  mem_len_i,
    input logic        mem_addr_ack_i,
    input logic        mem_data_valid_i
);

    // words still owed by memory after an acknowledge
    logic [3:0] beats_left_q;
    // number of property failures so far
    int         fail_count = 0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beats_left_q <= '0;
        end else if (mem_addr_valid_i && mem_addr_ack_i) begin
            beats_left_q <= mem_len_i;
        end else if (mem_data_valid_i && (beats_left_q != 4'd0)) begin
            beats_left_q <= beats_left_q - 1'b1;
        end
    end

    addr_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_addr_valid_i && !mem_addr_ack_i) |=>
            (mem_addr_valid_i && $stable(mem_addr_i) && $stable(mem_len_i)))
        else begin
            $error("memory request dropped or changed before its acknowledge");
            fail_count++;
        end

    ready_low_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_addr_valid_i || (beats_left_q != 4'd0)) |-> !fetch_ready_i)
        else begin
            $error("fetch accepted while a memory transfer is in progress");
            fail_count++;
        end

    quiet_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i |=> !dec_valid_i)
        else begin
            $error("decode response in the cycle after a flush");
            fail_count++;
        end

endmodule

bind icache_top icache_assertions u_assertions (
    .clk              (clk),
    .rst_n            (rst_n),
    .flush_i          (flush_i),
    .fetch_ready_i    (fetch_ready_o),
    .dec_valid_i      (dec_valid_o),
    .mem_addr_valid_i (mem_addr_valid_o),
    .mem_addr_i       (mem_addr_o),
    .mem_len_i        (mem_len_o),
    .mem_addr_ack_i   (mem_addr_ack_i),
    .mem_data_valid_i (mem_data_valid_i)
);

//--- testbench/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;

    localparam int unsigned NUM_TESTS    = 6;
    localparam int unsigned RESET_CYCLES = 10;
    // the data RAM clear walks four pairs per set
    localparam int unsigned CLEAR_CYCLES = SET_NUM * 4;
    localparam int unsigned WATCHDOG_CYCLES = RESET_CYCLES + CLEAR_CYCLES + NUM_TESTS * 200;

    logic        clk;
    logic        rst_n;
    logic        fetch_valid_i;
    fetch_req_t  fetch_req_i;
    logic        fetch_ready_o;
    logic        dec_valid_o;
    decode_pkt_t dec_pkt_o;
    logic        mem_addr_valid_o;
    logic [31:0] mem_addr_o;
    logic [3:0]  mem_len_o;
    logic        mem_addr_ack_i;
    logic        mem_data_valid_i;
    logic [31:0] mem_data_i;
    logic        cacop_valid_i;
    cacop_req_t  cacop_req_i;
    logic        cacop_ready_o;
    logic        cacop_done_o;
    window_csr_t csr_window_i;
    logic        flush_i;

    decode_pkt_t exp_q[$];
    logic [15:0] lfsr_q;
    logic [31:0] mem_last_addr;
    logic [3:0]  mem_last_len;
    int          mem_reqs = 0;
    int          checks = 0;
    int          errors = 0;
    int          err_mark = 0;
    int          assert_seen = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       test_name;

    icache_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // right-shifting form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int unsigned v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // every address bit reaches the word
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ (addr << 3) ^ 32'h6B2D_91C4;
    endfunction

    // window rule applied before reading the aligned pair from memory
    function automatic decode_pkt_t expect_pkt(input logic [31:0] pc, input logic [1:0] mask,
                                               input window_csr_t csr);
        logic [31:0] pa;
        decode_pkt_t pkt;
        pa = pc;
        if (csr.en && (pc[31:29] == csr.vseg)) begin
            pa[31:29] = csr.pseg;
        end
        pa[2:0]      = 3'b000;
        pkt.pc       = pc;
        pkt.mask     = mask;
        pkt.insts[0] = mem_word(pa);
        pkt.insts[1] = mem_word(pa + 32'd4);
        return pkt;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    initial begin : memory_model
        int unsigned delay;
        logic [31:0] addr;
        logic [3:0]  len;
        lfsr_q           = 16'd54499;
        mem_addr_ack_i   = 1'b0;
        mem_data_valid_i = 1'b0;
        mem_data_i       = '0;
        forever begin
            @(negedge clk);
            if ((rst_n === 1'b1) && (mem_addr_valid_o === 1'b1)) begin
                addr          = mem_addr_o;
                len           = mem_len_o;
                mem_last_addr = addr;
                mem_last_len  = len;
                mem_reqs++;
                draw_bits(2, delay);
                repeat (delay) @(negedge clk);
                mem_addr_ack_i = 1'b1;
                @(negedge clk);
                mem_addr_ack_i = 1'b0;
                for (int i = 0; i < len; i++) begin
                    draw_bits(2, delay);
                    repeat (delay % 3) @(negedge clk);
                    mem_data_valid_i = 1'b1;
                    mem_data_i       = mem_word(addr + 32'(4 * i));
                    @(negedge clk);
                    mem_data_valid_i = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin : response_check
        decode_pkt_t want;
        if ((rst_n === 1'b1) && (dec_valid_o === 1'b1)) begin
            checks++;
            assert (exp_q.size() != 0) else begin
                $display("unexpected decode response at %0t ns with no fetch outstanding", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                check_value("dec_pkt_o.pc", dec_pkt_o.pc, want.pc);
                check_value("dec_pkt_o.mask", 32'(dec_pkt_o.mask), 32'(want.mask));
                // slots outside the mask carry no data
                if (want.mask[0]) begin
                    check_value("dec_pkt_o.insts[0]", dec_pkt_o.insts[0], want.insts[0]);
                end
                if (want.mask[1]) begin
                    check_value("dec_pkt_o.insts[1]", dec_pkt_o.insts[1], want.insts[1]);
                end
            end
        end
    end

    task automatic fetch_pair(input logic [31:0] pc, input logic [1:0] mask,
                              input logic flush_lookup);
        @(negedge clk);
        fetch_valid_i    = 1'b1;
        fetch_req_i.pc   = pc;
        fetch_req_i.mask = mask;
        do begin
            @(posedge clk);
        end while (fetch_ready_o !== 1'b1);
        // a flushed lookup owes the decoder nothing
        if (!flush_lookup) begin
            exp_q.push_back(expect_pkt(pc, mask, csr_window_i));
        end
        @(negedge clk);
        fetch_valid_i = 1'b0;
        if (flush_lookup) begin
            flush_i = 1'b1;
            @(negedge clk);
            flush_i = 1'b0;
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        do begin
            @(posedge clk);
        end while (fetch_ready_o !== 1'b1);
    endtask

    task automatic run_cacop(input cacop_req_t req);
        int waited;
        int want_wait;
        want_wait = (req.op == 2'd2) ? 2 : 1;
        @(negedge clk);
        cacop_valid_i = 1'b1;
        cacop_req_i   = req;
        do begin
            @(posedge clk);
        end while (cacop_ready_o !== 1'b1);
        @(negedge clk);
        cacop_valid_i = 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while ((cacop_done_o !== 1'b1) && (waited < 8));
        checks++;
        assert (cacop_done_o === 1'b1) else begin
            $display("cacop_done_o never pulsed after maintenance op %0d at %0t ns",
                     req.op, $time);
            errors++;
        end
        if (cacop_done_o === 1'b1) begin
            check_value("cacop_done_o latency", waited, want_wait);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        int new_fails;
        new_fails   = u_dut.u_assertions.fail_count - assert_seen;
        assert_seen = u_dut.u_assertions.fail_count;
        checks++;
        assert (new_fails == 0) else begin
            $display("%0d bus protocol assertions failed by %0t ns", new_fails, $time);
            errors += new_fails;
        end
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d (%s): ok", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("test %0d (%s): %0d errors", tests_run, test_name, errors - err_mark);
        end
    endtask

    initial begin : main_seq
        int         reqs;
        cacop_req_t req;
        rst_n         = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_req_i   = '0;
        cacop_valid_i = 1'b0;
        cacop_req_i   = '0;
        csr_window_i  = '0;
        flush_i       = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // RAMs clear themselves before ready rises
        do begin
            @(posedge clk);
        end while (fetch_ready_o !== 1'b1);

        begin_test("cold miss then hit");
        reqs = mem_reqs;
        fetch_pair(32'h0000_1048, 2'b11, 1'b0);
        check_value("memory request count", mem_reqs, reqs + 1);
        check_value("mem_addr_o", mem_last_addr, 32'h0000_1040);
        check_value("mem_len_o", 32'(mem_last_len), 32'd8);
        fetch_pair(32'h0000_1048, 2'b11, 1'b0);
        check_value("memory request count", mem_reqs, reqs + 1);
        end_test();

        begin_test("uncached window");
        @(negedge clk);
        csr_window_i = '{en: 1'b1, vseg: 3'd5, pseg: 3'd0, cached: 1'b0};
        fetch_pair(32'hA000_2000, 2'b01, 1'b0);
        check_value("mem_addr_o", mem_last_addr, 32'h0000_2000);
        check_value("mem_len_o", 32'(mem_last_len), 32'd1);
        fetch_pair(32'hA000_2000, 2'b10, 1'b0);
        check_value("mem_addr_o", mem_last_addr, 32'h0000_2004);
        check_value("mem_len_o", 32'(mem_last_len), 32'd1);
        fetch_pair(32'hA000_2000, 2'b11, 1'b0);
        check_value("mem_addr_o", mem_last_addr, 32'h0000_2000);
        check_value("mem_len_o", 32'(mem_last_len), 32'd2);
        end_test();

        // in set 0x10 A fills way 0 and B way 1, then C evicts A
        begin_test("eviction at one index");
        @(negedge clk);
        csr_window_i = '0;
        fetch_pair(32'h0001_0208, 2'b11, 1'b0);
        fetch_pair(32'h0002_0208, 2'b11, 1'b0);
        fetch_pair(32'h0003_0208, 2'b11, 1'b0);
        reqs = mem_reqs;
        fetch_pair(32'h0001_0208, 2'b11, 1'b0);
        check_value("memory request count", mem_reqs, reqs + 1);
        reqs = mem_reqs;
        fetch_pair(32'h0003_0208, 2'b11, 1'b0);
        check_value("memory request count", mem_reqs, reqs);
        end_test();

        // fresh set 0x20 fills way 0 first
        begin_test("index invalidate");
        fetch_pair(32'h0004_0410, 2'b01, 1'b0);
        req                        = '0;
        req.op                     = 2'd0;
        req.addr.index_view.index  = 7'h20;
        req.addr.index_view.way    = 1'b0;
        run_cacop(req);
        reqs = mem_reqs;
        fetch_pair(32'h0004_0410, 2'b11, 1'b0);
        check_value("memory request count", mem_reqs, reqs + 1);
        end_test();

        // in set 0x30 a plain line fills way 0 and a windowed line way 1
        begin_test("hit invalidate");
        @(negedge clk);
        csr_window_i = '{en: 1'b1, vseg: 3'd4, pseg: 3'd0, cached: 1'b1};
        fetch_pair(32'h0005_0600, 2'b11, 1'b0);
        fetch_pair(32'h8006_0600, 2'b11, 1'b0);
        req         = '0;
        req.op      = 2'd2;
        req.addr.va = 32'h8006_0600;
        run_cacop(req);
        reqs = mem_reqs;
        fetch_pair(32'h0005_0600, 2'b11, 1'b0);
        check_value("memory request count", mem_reqs, reqs);
        fetch_pair(32'h8006_0600, 2'b10, 1'b0);
        check_value("memory request count", mem_reqs, reqs + 1);
        end_test();

        begin_test("flush in lookup");
        @(negedge clk);
        csr_window_i = '0;
        reqs = mem_reqs;
        fetch_pair(32'h0000_1048, 2'b11, 1'b1);
        fetch_pair(32'h0000_1050, 2'b11, 1'b0);
        check_value("memory request count", mem_reqs, reqs);
        end_test();

        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/addr_window.sv
`timescale 1ns/1ps

module addr_window (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        en_i,
    input  logic [31:0]                 va_i,
    input  icache_bus_pkg::window_csr_t csr_i,
    output icache_bus_pkg::xlate_t      xlate_o
);

    import icache_bus_pkg::*;

    xlate_t xlate_d;
    logic   in_window;

    // top segment swap, everything outside the window is cached
    always_comb begin
        in_window        = csr_i.en && (va_i[31:29] == csr_i.vseg);
        xlate_d.pa       = in_window ? {csr_i.pseg, va_i[28:0]} : va_i;
        xlate_d.uncached = in_window && !csr_i.cached;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xlate_o <= '0;
        end else if (en_i) begin
            xlate_o <= xlate_d;
        end
    end

endmodule

//--- verilog/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram #(
    parameter int unsigned WIDTH = 32,
    parameter int unsigned DEPTH = 128
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rd_en_i,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
    output logic [WIDTH-1:0]         rd_data_o,
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  logic [WIDTH-1:0]         wr_data_i,
    output logic                     clear_busy_o
);

    localparam int unsigned AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    clear_addr_q;
    logic             wr_fire;

    assign wr_fire = wr_en_i && !clear_busy_o;

    // walk every entry once after reset, writing zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clear_addr_q <= '0;
            clear_busy_o <= 1'b1;
        end else if (clear_busy_o) begin
            clear_addr_q <= clear_addr_q + 1'b1;
            clear_busy_o <= (clear_addr_q != AW'(DEPTH - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (clear_busy_o) begin
            mem[clear_addr_q] <= '0;
        end else if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // same-address write goes straight to the read output
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            if (wr_fire && (wr_addr_i == rd_addr_i)) begin
                rd_data_o <= wr_data_i;
            end else begin
                rd_data_o <= mem[rd_addr_i];
            end
        end
    end

endmodule

//--- verilog/icache_bus_pkg.sv
package icache_bus_pkg;

    // request from the fetch stage, pc is 8-byte aligned
    typedef struct packed {
        logic [31:0] pc;
        logic [1:0]  mask;
    } fetch_req_t;

    // instruction pair to the decoder, insts[0] is the low word
    typedef struct packed {
        logic [31:0]      pc;
        logic [1:0]       mask;
        logic [1:0][31:0] insts;
    } decode_pkt_t;

    typedef struct packed {
        logic                 v;
        icache_cfg_pkg::tag_t tag;
    } tag_entry_t;

    // index-invalidate form, way sits in bit 0 and index in [11:5]
    typedef struct packed {
        logic [31-icache_cfg_pkg::INDEX_W-5:0] hi;
        icache_cfg_pkg::index_t                index;
        logic [3:0]                            pad;
        logic                                  way;
    } cacop_index_t;

    // ops 0/1 read index_view, op 2 reads va
    typedef union packed {
        cacop_index_t index_view;
        logic [31:0]  va;
    } cacop_addr_u;

    typedef struct packed {
        logic [1:0]  op;
        cacop_addr_u addr;
    } cacop_req_t;

    typedef struct packed {
        logic       en;
        logic [2:0] vseg;
        logic [2:0] pseg;
        logic       cached;
    } window_csr_t;

    typedef struct packed {
        logic [31:0] pa;
        logic        uncached;
    } xlate_t;

endpackage

//--- verilog/icache_cfg_pkg.sv
package icache_cfg_pkg;

    // geometry of the cache
    localparam int unsigned WAY_NUM    = 2;
    localparam int unsigned LINE_BYTES = 32;
    localparam int unsigned SET_NUM    = 128;

    // address split: tag | index | offset
    localparam int unsigned OFFSET_W = $clog2(LINE_BYTES);
    localparam int unsigned INDEX_W  = $clog2(SET_NUM);
    localparam int unsigned TAG_W    = 32 - INDEX_W - OFFSET_W;

    // words per refill burst
    localparam int unsigned BEATS_PER_LINE = LINE_BYTES / 4;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

endpackage

//--- verilog/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl #(
    parameter int unsigned WAY_NUM = 2
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       flush_i,
    input  logic                                       fetch_valid_i,
    input  icache_bus_pkg::fetch_req_t                 fetch_req_i,
    output logic                                       fetch_ready_o,
    output logic                                       dec_valid_o,
    output icache_bus_pkg::decode_pkt_t                dec_pkt_o,
    output logic                                       mem_addr_valid_o,
    output logic [31:0]                                mem_addr_o,
    output logic [3:0]                                 mem_len_o,
    input  logic                                       mem_addr_ack_i,
    input  logic                                       mem_data_valid_i,
    input  logic [31:0]                                mem_data_i,
    input  logic                                       cacop_valid_i,
    input  icache_bus_pkg::cacop_req_t                 cacop_req_i,
    output logic                                       cacop_ready_o,
    output logic                                       cacop_done_o,
    output logic [31:0]                                lookup_va_o,
    output logic                                       lookup_en_o,
    input  icache_bus_pkg::xlate_t                     xlate_i,
    input  icache_bus_pkg::tag_entry_t [WAY_NUM-1:0]   tag_rd_i,
    input  logic [WAY_NUM-1:0][1:0][31:0]              data_rd_i,
    output logic [WAY_NUM-1:0]                         tag_wr_en_o,
    output logic [WAY_NUM-1:0]                         data_wr_en_o,
    output icache_cfg_pkg::index_t                     wr_index_o,
    output logic [1:0]                                 wr_word_o,
    output icache_bus_pkg::tag_entry_t                 tag_wr_o,
    output logic [1:0][31:0]                           data_wr_o,
    input  logic                                       clear_busy_i
);

    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;

    typedef enum logic [2:0] {
        NORMAL,
        MISS_REQ,
        MISS_DATA,
        UNC_REQ,
        UNC_DATA,
        CACOP_CMP
    } state_e;

    state_e             state_q, state_d;
    fetch_req_t         s2_req_q;
    logic               s2_valid_q;
    logic [SET_NUM-1:0] repl_q;
    logic [2:0]         beat_q;
    logic [31:0]        lo_word_q;
    logic [1:0][31:0]   hold_q;
    logic               unc_resp_q;
    logic               done_q;

    logic [WAY_NUM-1:0] hit;
    logic [WAY_NUM-1:0] victim;
    logic [1:0][31:0]   hit_data;
    index_t             line_index;
    logic               s2_live, s2_hit, s2_miss;
    logic               idle, fetch_acc, cacop_acc, cop_hit_inv;
    logic               beat, last_beat, pair_wr, pair_match;

    // tag compare, shared by fetch lookup and hit-invalidate
    always_comb begin
        hit_data = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            hit[w] = tag_rd_i[w].v && (tag_rd_i[w].tag == xlate_i.pa[31 -: TAG_W]);
            if (hit[w]) begin
                hit_data = data_rd_i[w];
            end
        end
    end

    // index bits are untouched by the window, so pa and va agree here
    assign line_index = xlate_i.pa[OFFSET_W +: INDEX_W];

    always_comb begin
        victim                     = '0;
        victim[repl_q[line_index]] = 1'b1;
    end

    assign s2_live = s2_valid_q && !flush_i && (state_q == NORMAL);
    assign s2_hit  = s2_live && !xlate_i.uncached && (|hit);
    assign s2_miss = s2_live && (xlate_i.uncached || !(|hit));

    // maintenance wins over fetch in the same cycle
    assign idle          = (state_q == NORMAL) && !clear_busy_i && !s2_miss;
    assign cacop_ready_o = idle;
    assign fetch_ready_o = idle && !cacop_valid_i;
    assign fetch_acc     = fetch_valid_i && fetch_ready_o;
    assign cacop_acc     = cacop_valid_i && idle;
    assign cop_hit_inv   = cacop_acc && (cacop_req_i.op == 2'd2);
    assign cacop_done_o  = done_q;

    assign lookup_va_o = cacop_acc ? cacop_req_i.addr.va : fetch_req_i.pc;
    assign lookup_en_o = fetch_acc || cop_hit_inv;

    // xlate_i and s2 hold still until the transfer ends
    assign mem_addr_valid_o = s2_miss || (state_q == MISS_REQ) || (state_q == UNC_REQ);
    assign mem_addr_o = xlate_i.uncached ?
                        {xlate_i.pa[31:3], s2_req_q.mask == 2'b10, 2'b00} :
                        {xlate_i.pa[31:OFFSET_W], {OFFSET_W{1'b0}}};
    assign mem_len_o  = !xlate_i.uncached ? 4'(BEATS_PER_LINE) :
                        (s2_req_q.mask == 2'b11) ? 4'd2 : 4'd1;

    assign beat       = mem_data_valid_i && ((state_q == MISS_DATA) || (state_q == UNC_DATA));
    assign last_beat  = beat && ({1'b0, beat_q} == mem_len_o - 4'd1);
    assign pair_wr    = beat && beat_q[0] && (state_q == MISS_DATA);
    assign pair_match = pair_wr && (beat_q[2:1] == s2_req_q.pc[OFFSET_W-1:3]);

    // RAM write port: refill pairs, refill tag, invalidates
    always_comb begin
        wr_index_o   = line_index;
        wr_word_o    = beat_q[2:1];
        data_wr_o    = {mem_data_i, lo_word_q};
        tag_wr_o     = '0;
        tag_wr_en_o  = '0;
        data_wr_en_o = pair_wr ? victim : '0;
        if ((state_q == MISS_DATA) && last_beat) begin
            tag_wr_o.v   = 1'b1;
            tag_wr_o.tag = xlate_i.pa[31 -: TAG_W];
            tag_wr_en_o  = victim;
        end
        if (cacop_acc && !cop_hit_inv) begin
            wr_index_o = cacop_req_i.addr.index_view.index;
            tag_wr_en_o[cacop_req_i.addr.index_view.way] = 1'b1;
        end
        if (state_q == CACOP_CMP) begin
            tag_wr_en_o = hit;
        end
    end

    always_comb begin
        dec_pkt_o.pc    = s2_req_q.pc;
        dec_pkt_o.mask  = s2_req_q.mask;
        dec_pkt_o.insts = unc_resp_q ? hold_q : hit_data;
        dec_valid_o     = s2_hit || (unc_resp_q && !flush_i);
        if (state_q == MISS_DATA) begin
            // the wanted pair may be the one arriving right now
            dec_pkt_o.insts = pair_match ? {mem_data_i, lo_word_q} : hold_q;
            dec_valid_o     = last_beat && s2_valid_q && !flush_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            NORMAL: begin
                if (s2_miss) begin
                    if (xlate_i.uncached) begin
                        state_d = mem_addr_ack_i ? UNC_DATA : UNC_REQ;
                    end else begin
                        state_d = mem_addr_ack_i ? MISS_DATA : MISS_REQ;
                    end
                end else if (cop_hit_inv) begin
                    state_d = CACOP_CMP;
                end
            end
            MISS_REQ: begin
                if (mem_addr_ack_i) begin
                    state_d = MISS_DATA;
                end
            end
            UNC_REQ: begin
                if (mem_addr_ack_i) begin
                    state_d = UNC_DATA;
                end
            end
            MISS_DATA, UNC_DATA: begin
                if (last_beat) begin
                    state_d = NORMAL;
                end
            end
            default: begin
                state_d = NORMAL;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= NORMAL;
            s2_valid_q <= 1'b0;
            repl_q     <= '0;
            beat_q     <= '0;
            unc_resp_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            state_q    <= state_d;
            unc_resp_q <= (state_q == UNC_DATA) && last_beat && s2_valid_q && !flush_i;
            done_q     <= (cacop_acc && !cop_hit_inv) || (state_q == CACOP_CMP);
            // a missing request stays in s2 until its data is back
            if (flush_i || last_beat) begin
                s2_valid_q <= 1'b0;
            end else if ((state_q == NORMAL) && !s2_miss) begin
                s2_valid_q <= fetch_acc;
            end
            if (state_q == NORMAL) begin
                beat_q <= '0;
            end else if (beat) begin
                beat_q <= beat_q + 1'b1;
            end
            if ((state_q == MISS_DATA) && last_beat) begin
                repl_q[line_index] <= ~repl_q[line_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_acc) begin
            s2_req_q <= fetch_req_i;
        end
        if (beat && !beat_q[0]) begin
            lo_word_q <= mem_data_i;
        end
        if (pair_match) begin
            hold_q <= {mem_data_i, lo_word_q};
        end else if (beat && (state_q == UNC_DATA)) begin
            // a lone high word lands in slot 1
            hold_q[beat_q[0] | (s2_req_q.mask == 2'b10)] <= mem_data_i;
        end
    end

endmodule

//--- verilog/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
    parameter int unsigned WAY_NUM = icache_cfg_pkg::WAY_NUM,
    parameter int unsigned SET_NUM = icache_cfg_pkg::SET_NUM
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        fetch_valid_i,
    input  icache_bus_pkg::fetch_req_t  fetch_req_i,
    output logic                        fetch_ready_o,
    output logic                        dec_valid_o,
    output icache_bus_pkg::decode_pkt_t dec_pkt_o,
    output logic                        mem_addr_valid_o,
    output logic [31:0]                 mem_addr_o,
    output logic [3:0]                  mem_len_o,
    input  logic                        mem_addr_ack_i,
    input  logic                        mem_data_valid_i,
    input  logic [31:0]                 mem_data_i,
    input  logic                        cacop_valid_i,
    input  icache_bus_pkg::cacop_req_t  cacop_req_i,
    output logic                        cacop_ready_o,
    output logic                        cacop_done_o,
    input  icache_bus_pkg::window_csr_t csr_window_i,
    input  logic                        flush_i
);

    import icache_cfg_pkg::*;
    import icache_bus_pkg::*;

    // four word pairs per line
    localparam int unsigned PAIRS = LINE_BYTES / 8;

    logic [31:0]                   lookup_va;
    logic                          lookup_en;
    xlate_t                        xlate;
    tag_entry_t [WAY_NUM-1:0]      tag_rd;
    logic [WAY_NUM-1:0][1:0][31:0] data_rd;
    logic [WAY_NUM-1:0]            tag_wr_en, data_wr_en;
    logic [WAY_NUM-1:0]            tag_busy, data_busy;
    index_t                        wr_index;
    logic [1:0]                    wr_word;
    tag_entry_t                    tag_wr;
    logic [1:0][31:0]              data_wr;

    addr_window u_window (
        .clk     (clk),
        .rst_n   (rst_n),
        .en_i    (lookup_en),
        .va_i    (lookup_va),
        .csr_i   (csr_window_i),
        .xlate_o (xlate)
    );

    for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
        dual_port_ram #(
            .WIDTH ($bits(tag_entry_t)),
            .DEPTH (SET_NUM)
        ) u_tag_ram (
            .clk          (clk),
            .rst_n        (rst_n),
            .rd_en_i      (lookup_en),
            .rd_addr_i    (lookup_va[OFFSET_W +: INDEX_W]),
            .rd_data_o    (tag_rd[w]),
            .wr_en_i      (tag_wr_en[w]),
            .wr_addr_i    (wr_index),
            .wr_data_i    (tag_wr),
            .clear_busy_o (tag_busy[w])
        );

        dual_port_ram #(
            .WIDTH ($bits(data_wr)),
            .DEPTH (SET_NUM * PAIRS)
        ) u_data_ram (
            .clk          (clk),
            .rst_n        (rst_n),
            .rd_en_i      (lookup_en),
            .rd_addr_i    (lookup_va[3 +: INDEX_W + 2]),
            .rd_data_o    (data_rd[w]),
            .wr_en_i      (data_wr_en[w]),
            .wr_addr_i    ({wr_index, wr_word}),
            .wr_data_i    (data_wr),
            .clear_busy_o (data_busy[w])
        );
    end

    icache_ctrl #(
        .WAY_NUM (WAY_NUM)
    ) u_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (flush_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_req_i      (fetch_req_i),
        .fetch_ready_o    (fetch_ready_o),
        .dec_valid_o      (dec_valid_o),
        .dec_pkt_o        (dec_pkt_o),
        .mem_addr_valid_o (mem_addr_valid_o),
        .mem_addr_o       (mem_addr_o),
        .mem_len_o        (mem_len_o),
        .mem_addr_ack_i   (mem_addr_ack_i),
        .mem_data_valid_i (mem_data_valid_i),
        .mem_data_i       (mem_data_i),
        .cacop_valid_i    (cacop_valid_i),
        .cacop_req_i      (cacop_req_i),
        .cacop_ready_o    (cacop_ready_o),
        .cacop_done_o     (cacop_done_o),
        .lookup_va_o      (lookup_va),
        .lookup_en_o      (lookup_en),
        .xlate_i          (xlate),
        .tag_rd_i         (tag_rd),
        .data_rd_i        (data_rd),
        .tag_wr_en_o      (tag_wr_en),
        .data_wr_en_o     (data_wr_en),
        .wr_index_o       (wr_index),
        .wr_word_o        (wr_word),
        .tag_wr_o         (tag_wr),
        .data_wr_o        (data_wr),
        .clear_busy_i     ((|tag_busy) || (|data_busy))
    );

endmodule
